/* Bender.yml */
package:
  name: lineFollower

sources:
  - lineFollowerPkg.sv
  - trackSampler.sv
  - missionTimers.sv
  - routeFsm.sv
  - statusDisplay.sv
  - motorDrive.sv
  - lineFollower.sv
  - target: test
    files:
      - tbLineFollower.sv

/* lineFollower.f */
lineFollowerPkg.sv
trackSampler.sv
missionTimers.sv
routeFsm.sv
statusDisplay.sv
motorDrive.sv
lineFollower.sv
tbLineFollower.sv

/* lineFollower.sv */
module lineFollower import lineFollowerPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        runEnable,
    input  trackRaw_t   track,
    output logic [15:0] led,
    output logic [3:0]  segDigit,
    output logic [6:0]  segDisplay,
    output motorCmd_t   motor
);

    roadCode_t    road;
    routeState_t  state;
    routeState_t  resumeState;
    logic [3:0]   checkPoints;
    timerStatus_t timers;

    trackSampler i_trackSampler (
        .clk   (clk),
        .rst   (rst),
        .track (track),
        .road  (road)
    );

    missionTimers i_missionTimers (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .timers (timers)
    );

    routeFsm i_routeFsm (
        .clk         (clk),
        .rst         (rst),
        .runEnable   (runEnable),
        .road        (road),
        .timers      (timers),
        .state       (state),
        .lastState   (),
        .resumeState (resumeState),
        .checkPoints (checkPoints)
    );

    statusDisplay i_statusDisplay (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .road        (road),
        .timers      (timers),
        .resumeState (resumeState),
        .checkPoints (checkPoints),
        .led         (led),
        .segDigit    (segDigit),
        .segDisplay  (segDisplay)
    );

    motorDrive i_motorDrive (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .motor (motor)
    );

endmodule

/* lineFollowerPkg.sv */
package lineFollowerPkg;

    // sensor pattern {left, mid, right} where a set bit sees the line
    typedef enum logic [2:0] {
        ROAD_LOST         = 3'b000,
        ROAD_RIGHT_SLIGHT = 3'b001,
        ROAD_STRAIGHT     = 3'b010,
        ROAD_RIGHT        = 3'b011,
        ROAD_LEFT_SLIGHT  = 3'b100,
        ROAD_TURN101      = 3'b101,
        ROAD_LEFT         = 3'b110,
        ROAD_TURN111      = 3'b111
    } roadCode_t;

    typedef enum logic [4:0] {
        IDLE         = 5'd0,
        START        = 5'd1,
        COUNT        = 5'd2,
        STRAIGHT     = 5'd3,
        CHOOSE       = 5'd4,
        LEFT         = 5'd5,
        RIGHT        = 5'd6,
        BACK         = 5'd7,
        LITTLE_LEFT  = 5'd8,
        LITTLE_RIGHT = 5'd9,
        STOP         = 5'd30,
        ERROR        = 5'd31
    } routeState_t;

    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } trackRaw_t;

    typedef struct packed {
        logic       pwmLeft;
        logic       pwmRight;
        logic [1:0] leftDir;
        logic [1:0] rightDir;
    } motorCmd_t;

    typedef struct packed {
        logic       countFinish;
        logic [1:0] countStep;
        logic       pauseDone;
        logic       backFlash;
        logic [2:0] lampPhase;
    } timerStatus_t;

    typedef struct packed {
        logic [3:0] digit0;
        logic [3:0] digit1;
        logic [3:0] digit2;
        logic [3:0] digit3;
    } digitCodes_t;

    // wheel direction pairs
    localparam logic [1:0] DIR_OFF = 2'b00;
    localparam logic [1:0] DIR_FWD = 2'b10;
    localparam logic [1:0] DIR_REV = 2'b01;

    // timer lengths at simulation scale
    localparam int TICK_WIDTH = 8;
    localparam logic [TICK_WIDTH-1:0] COUNT_STEP_TICKS = 4;
    localparam logic [TICK_WIDTH-1:0] STOP_PAUSE_TICKS = 12;
    localparam logic [TICK_WIDTH-1:0] FLASH_HALF_TICKS = 4;
    localparam logic [TICK_WIDTH-1:0] LAMP_STEP_TICKS  = 8;

    localparam int PWM_WIDTH = 4;
    localparam int PWM_PERIOD = 16;
    localparam logic [PWM_WIDTH-1:0] PWM_DUTY_FULL = 12;
    localparam logic [PWM_WIDTH-1:0] PWM_DUTY_SLOW = 6;

    localparam int SCAN_TICKS = 4;
    localparam int FILTER_DEPTH = 3;

    // active low segments in bit order {g, f, e, d, c, b, a}
    localparam logic [6:0] SEG_GLYPHS [16] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000,
        7'b0001000,  // 10 shows A
        7'b0111111,  // 11 shows a dash
        7'b1000111,  // 12 shows L
        7'b0000110,  // 13 shows E
        7'b0101111,  // 14 shows r
        7'b1111111   // 15 is blank
    };

endpackage

/* missionTimers.sv */
module missionTimers import lineFollowerPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  routeState_t  state,
    output timerStatus_t timers
);

    routeState_t           stateQ;
    logic [TICK_WIDTH-1:0] tick;
    logic [TICK_WIDTH-1:0] elapsed;
    logic [TICK_WIDTH-1:0] stepIndex;
    logic [TICK_WIDTH-1:0] flashIndex;
    logic [2:0]            lamp;
    logic                  timed;

    assign timed = state inside {COUNT, STOP, BACK, CHOOSE};

    // cycles since the state was entered and zero in its first cycle
    assign elapsed    = (state == stateQ) ? tick : '0;
    assign stepIndex  = elapsed / COUNT_STEP_TICKS;
    assign flashIndex = elapsed / FLASH_HALF_TICKS;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stateQ <= IDLE;
            tick   <= '0;
            lamp   <= 3'b001;
        end else begin
            stateQ <= state;
            if (!timed) begin
                tick <= '0;
            end else if (state != stateQ) begin
                tick <= TICK_WIDTH'(1);
            end else begin
                tick <= tick + 1'b1;
            end

            // choose lamp walks a single lit bit around
            if (state != CHOOSE) begin
                lamp <= 3'b001;
            end else if (elapsed % LAMP_STEP_TICKS == LAMP_STEP_TICKS - 1) begin
                lamp <= {lamp[1:0], lamp[2]};
            end
        end
    end

    always_comb begin
        timers.countStep   = (state == COUNT) ? stepIndex[1:0] : 2'b00;
        timers.countFinish = (state == COUNT) && (elapsed >= 4 * COUNT_STEP_TICKS - 1);
        // single pulse at the end of the pause
        timers.pauseDone   = (state == STOP) && (elapsed == STOP_PAUSE_TICKS - 1);
        timers.backFlash   = (state == BACK) && flashIndex[0];
        timers.lampPhase   = lamp;
    end

    // a pause only ends after the whole stop time
    assert property (@(posedge clk) disable iff (rst)
        timers.pauseDone |-> state == STOP && $past(state == STOP, STOP_PAUSE_TICKS - 1));

endmodule

/* motorDrive.sv */
module motorDrive import lineFollowerPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  routeState_t state,
    output motorCmd_t   motor
);

    logic [PWM_WIDTH-1:0] pwmCount;
    logic [PWM_WIDTH-1:0] dutyLeft;
    logic [PWM_WIDTH-1:0] dutyRight;
    logic [1:0]           dirLeft;
    logic [1:0]           dirRight;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCount <= '0;
        end else if (pwmCount == PWM_WIDTH'(PWM_PERIOD - 1)) begin
            pwmCount <= '0;
        end else begin
            pwmCount <= pwmCount + 1'b1;
        end
    end

    always_comb begin
        dirLeft   = DIR_OFF;
        dirRight  = DIR_OFF;
        dutyLeft  = '0;
        dutyRight = '0;
        case (state)
            STRAIGHT, COUNT: begin
                dirLeft   = DIR_FWD;
                dirRight  = DIR_FWD;
                dutyLeft  = PWM_DUTY_FULL;
                dutyRight = PWM_DUTY_FULL;
            end
            // slight corrections drive one wheel only
            LITTLE_LEFT: begin
                dirLeft  = DIR_FWD;
                dutyLeft = PWM_DUTY_SLOW;
            end
            LITTLE_RIGHT: begin
                dirRight  = DIR_FWD;
                dutyRight = PWM_DUTY_SLOW;
            end
            // spin on the spot
            LEFT, CHOOSE: begin
                dirLeft   = DIR_REV;
                dirRight  = DIR_FWD;
                dutyLeft  = PWM_DUTY_FULL;
                dutyRight = PWM_DUTY_FULL;
            end
            RIGHT: begin
                dirLeft   = DIR_FWD;
                dirRight  = DIR_REV;
                dutyLeft  = PWM_DUTY_FULL;
                dutyRight = PWM_DUTY_FULL;
            end
            BACK: begin
                dirLeft   = DIR_REV;
                dirRight  = DIR_REV;
                dutyLeft  = PWM_DUTY_SLOW;
                dutyRight = PWM_DUTY_SLOW;
            end
            default: begin
                dirLeft = DIR_OFF;
            end
        endcase
    end

    assign motor = '{
        pwmLeft:  pwmCount < dutyLeft,
        pwmRight: pwmCount < dutyRight,
        leftDir:  dirLeft,
        rightDir: dirRight
    };

    // both bridge inputs high would brake hard
    assert property (@(posedge clk) disable iff (rst)
        motor.leftDir != 2'b11 && motor.rightDir != 2'b11);

endmodule

/* routeFsm.sv */
module routeFsm import lineFollowerPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         runEnable,
    input  roadCode_t    road,
    input  timerStatus_t timers,
    output routeState_t  state,
    output routeState_t  lastState,
    output routeState_t  resumeState,
    output logic [3:0]   checkPoints
);

    routeState_t nextState;
    routeState_t nextResume;
    logic [1:0]  rightCount;
    logic        rightDone;
    logic        straightGroup;

    assign straightGroup = state inside {STRAIGHT, LITTLE_LEFT, LITTLE_RIGHT};

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        case (state)
            IDLE:  nextState = runEnable ? START : IDLE;
            START: nextState = (road == ROAD_STRAIGHT) ? COUNT : START;
            COUNT: nextState = timers.countFinish ? STRAIGHT : COUNT;
            STRAIGHT, LITTLE_LEFT, LITTLE_RIGHT: begin
                case (road)
                    ROAD_LOST: begin
                        nextState  = STOP;
                        nextResume = BACK;
                    end
                    ROAD_TURN111:      nextState = checkPoints[1] ? CHOOSE : STRAIGHT;
                    ROAD_LEFT_SLIGHT:  nextState = LITTLE_LEFT;
                    ROAD_RIGHT_SLIGHT: nextState = LITTLE_RIGHT;
                    default:           nextState = STRAIGHT;
                endcase
            end
            CHOOSE: begin
                if (road == ROAD_TURN101) begin
                    nextState  = STOP;
                    nextResume = LEFT;
                end else if (road == ROAD_TURN111 && checkPoints[0]) begin
                    nextState = STRAIGHT;
                end
            end
            LEFT: begin
                if (road == ROAD_TURN101) begin
                    nextState  = STOP;
                    nextResume = RIGHT;
                end else if (road == ROAD_TURN111 && checkPoints[2]) begin
                    nextState  = STOP;
                    nextResume = STRAIGHT;
                end
            end
            RIGHT: begin
                // a 101 after a confirmed turn means the car is off course
                if (road == ROAD_TURN101 && rightDone) begin
                    nextState = ERROR;
                end else if (road == ROAD_TURN111 && checkPoints[3] && rightDone) begin
                    nextState  = STOP;
                    nextResume = STRAIGHT;
                end
            end
            BACK: begin
                if (road == ROAD_TURN111) begin
                    nextState  = STOP;
                    nextResume = LEFT;
                end
            end
            STOP:    nextState = timers.pauseDone ? resumeState : STOP;
            ERROR:   nextState = runEnable ? ERROR : IDLE;
            default: nextState = IDLE;
        endcase
        // the run switch overrides everything
        if (!runEnable) begin
            nextState = IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            lastState   <= IDLE;
            resumeState <= IDLE;
        end else begin
            state       <= nextState;
            lastState   <= state;
            resumeState <= nextResume;
        end
    end

    // checkpoints mark that the car has moved off the last junction mark
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            checkPoints <= '0;
            rightCount  <= '0;
            rightDone   <= 1'b0;
        end else begin
            if (state == CHOOSE && road != ROAD_TURN111)
                checkPoints[0] <= 1'b1;
            else if (state != CHOOSE)
                checkPoints[0] <= 1'b0;

            if (lastState == COUNT || (straightGroup && road != ROAD_TURN111))
                checkPoints[1] <= 1'b1;
            else if (!straightGroup)
                checkPoints[1] <= 1'b0;

            if (state == LEFT && road != ROAD_TURN111)
                checkPoints[2] <= 1'b1;
            else if (state != LEFT)
                checkPoints[2] <= 1'b0;

            if (state == RIGHT && road != ROAD_TURN111)
                checkPoints[3] <= 1'b1;
            else if (state != RIGHT)
                checkPoints[3] <= 1'b0;

            // right turn confirmed after a few cycles on the 111 mark
            if (state == RIGHT && road == ROAD_TURN111) begin
                rightCount <= rightCount + 1'b1;
                if (rightCount >= 2'd2) begin
                    rightDone <= 1'b1;
                end
            end else if (state != RIGHT) begin
                rightCount <= '0;
                rightDone  <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, START, COUNT, STRAIGHT, CHOOSE, LEFT, RIGHT, BACK,
                      LITTLE_LEFT, LITTLE_RIGHT, STOP, ERROR});

endmodule

/* statusDisplay.sv */
module statusDisplay import lineFollowerPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  routeState_t  state,
    input  roadCode_t    road,
    input  timerStatus_t timers,
    input  routeState_t  resumeState,
    input  logic [3:0]   checkPoints,
    output logic [15:0]  led,
    output logic [3:0]   segDigit,
    output logic [6:0]   segDisplay
);

    logic [4:0]                    lamp;
    logic [5:0]                    bar;
    logic [3:0]                    resumeCode;
    digitCodes_t                   codes;
    logic [$clog2(SCAN_TICKS)-1:0] scanCount;
    logic [1:0]                    scanIndex;
    logic [3:0]                    scanCode;

    always_comb begin
        case (state)
            START:                              lamp = 5'b00001;
            COUNT:                              lamp = 5'b00010;
            STRAIGHT, LITTLE_LEFT, LITTLE_RIGHT: lamp = 5'b01000;
            CHOOSE:                             lamp = {timers.lampPhase, 2'b00};
            LEFT:                               lamp = 5'b10000;
            RIGHT:                              lamp = 5'b00100;
            STOP:                               lamp = 5'b11100;
            BACK:                               lamp = 5'b01010;
            ERROR:                              lamp = 5'b11111;
            default:                            lamp = 5'b00000;
        endcase

        case (state)
            COUNT:    bar = timers.countStep[0] ? 6'b000000 : 6'b111111;
            STRAIGHT: bar = 6'b001100;
            LEFT:     bar = 6'b110000;
            RIGHT:    bar = 6'b000011;
            STOP:     bar = 6'b111111;
            BACK:     bar = timers.backFlash ? 6'b000000 : 6'b111111;
            default:  bar = 6'b000000;
        endcase
    end

    assign led = {lamp, 1'b0, bar, 1'b0, road};

    // glyph for where the car goes after a stop
    always_comb begin
        case (resumeState)
            IDLE:       resumeCode = 4'd12;
            STRAIGHT:   resumeCode = 4'd0;
            LEFT, BACK: resumeCode = 4'd13;
            default:    resumeCode = 4'd15;
        endcase
    end

    always_comb begin
        case (state)
            IDLE:  codes = '{4'd1, 4'd12, 4'd13, 4'd14};
            START: codes = '{4'd11, 4'd11, 4'd11, 4'd11};
            COUNT: codes = '{4'd11, 4'd11, 4'd11, 4'd3 - {2'b00, timers.countStep}};
            STRAIGHT, LITTLE_LEFT, LITTLE_RIGHT:
                codes = '{4'd10, 4'd2, 4'd11, {3'b000, checkPoints[1]}};
            CHOOSE: codes = '{4'd10, 4'd1, 4'd11, {3'b000, checkPoints[0]}};
            LEFT:   codes = '{4'd10, 4'd3, 4'd11, {3'b000, checkPoints[2]}};
            RIGHT:  codes = '{4'd10, 4'd4, 4'd11, {3'b000, checkPoints[3]}};
            BACK:   codes = '{4'd0, 4'd0, 4'd0, resumeCode};
            STOP:   codes = '{{3'b000, timers.pauseDone}, 4'd0, 4'd0, resumeCode};
            default: codes = '{4'd15, 4'd15, 4'd15, 4'd15};
        endcase
    end

    // one digit lit at a time
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanCount <= '0;
            scanIndex <= '0;
        end else if (scanCount == SCAN_TICKS - 1) begin
            scanCount <= '0;
            scanIndex <= scanIndex + 1'b1;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    always_comb begin
        case (scanIndex)
            2'd0:    scanCode = codes.digit0;
            2'd1:    scanCode = codes.digit1;
            2'd2:    scanCode = codes.digit2;
            default: scanCode = codes.digit3;
        endcase
    end

    assign segDigit   = ~(4'b0001 << scanIndex);
    assign segDisplay = SEG_GLYPHS[scanCode];

endmodule

/* tbLineFollower.sv */
module tbLineFollower import lineFollowerPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // about ten times the cycles of all directed tests together
    localparam int TIMEOUT_CYCLES   = 3000;
    localparam int LAMP_WAIT_CYCLES = 200;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    localparam logic [1:0] WHEEL_OFF = 2'b00;
    localparam logic [1:0] WHEEL_FWD = 2'b10;
    localparam logic [1:0] WHEEL_REV = 2'b01;

    // state lamp on led[15:11]
    localparam logic [4:0] LAMP_IDLE     = 5'b00000;
    localparam logic [4:0] LAMP_START    = 5'b00001;
    localparam logic [4:0] LAMP_COUNT    = 5'b00010;
    localparam logic [4:0] LAMP_STRAIGHT = 5'b01000;
    localparam logic [4:0] LAMP_CHOOSE   = 5'b00100;
    localparam logic [4:0] LAMP_LEFT     = 5'b10000;
    localparam logic [4:0] LAMP_STOP     = 5'b11100;
    localparam logic [4:0] LAMP_BACK     = 5'b01010;

    logic        clk;
    logic        rst;
    logic        runEnable;
    trackRaw_t   track;
    logic [15:0] led;
    logic [3:0]  segDigit;
    logic [6:0]  segDisplay;
    motorCmd_t   motor;
    logic [31:0] lfsr;
    int          cycleCount = 0;

    lineFollower i_lineFollower (
        .clk        (clk),
        .rst        (rst),
        .runEnable  (runEnable),
        .track      (track),
        .led        (led),
        .segDigit   (segDigit),
        .segDisplay (segDisplay),
        .motor      (motor)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES) begin
            abortRun("simulation ran past the cycle limit without finishing the tests");
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkLedLamp(input string name, input logic [4:0] actual,
                                input logic [4:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkLedBar(input string name, input logic [5:0] actual,
                               input logic [5:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkRoad(input string name, input roadCode_t actual,
                             input roadCode_t expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    // pwm bits only compared when withPwm is set
    task automatic checkMotor(input string name, input motorCmd_t actual,
                              input motorCmd_t expected, input logic withPwm);
        motorCmd_t seen;
        seen = actual;
        if (!withPwm) begin
            seen.pwmLeft  = expected.pwmLeft;
            seen.pwmRight = expected.pwmRight;
        end
        if (seen !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkDigitSelect(input string name, input logic [3:0] actual,
                                    input logic [3:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkGlyph(input string name, input logic [6:0] actual,
                              input logic [6:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic takeBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return outBit;
    endfunction

    function automatic int takeBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(takeBit());
        end
        return value;
    endfunction

    task automatic driveInputs(input logic run, input roadCode_t code);
        @(posedge clk);
        runEnable <= run;
        track     <= trackRaw_t'(code);
    endtask

    task automatic settleCycles(input int count);
        repeat (count) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic waitLamp(input logic [4:0] lamp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (led[15:11] !== lamp) begin
            cycles++;
            if (cycles >= LAMP_WAIT_CYCLES) begin
                abortRun($sformatf("state lamp did not reach %b within %0d cycles",
                                   lamp, LAMP_WAIT_CYCLES));
            end
            @(negedge clk);
        end
    endtask

    task automatic testReset();
        @(negedge clk);
        checkLedLamp("led[15:11]", led[15:11], LAMP_IDLE);
        checkLedBar("led[9:4]", led[9:4], 6'b000000);
        checkRoad("led[2:0]", roadCode_t'(led[2:0]), ROAD_LOST);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_OFF, WHEEL_OFF}), 1'b1);
        checkDigitSelect("segDigit", segDigit, 4'b1110);
        // idle shows 1 on digit 0
        checkGlyph("segDisplay", segDisplay, SEG_GLYPHS[1]);
    endtask

    task automatic testRoadCodes();
        roadCode_t order [8];
        roadCode_t swap;
        int        pick;
        for (int i = 0; i < 8; i++) begin
            order[i] = roadCode_t'(3'(i));
        end
        // shuffle the patterns
        for (int i = 7; i > 0; i--) begin
            pick        = takeBits(3) % (i + 1);
            swap        = order[i];
            order[i]    = order[pick];
            order[pick] = swap;
        end
        foreach (order[i]) begin
            driveInputs(1'b0, order[i]);
            settleCycles(9);
            checkRoad("led[2:0]", roadCode_t'(led[2:0]), order[i]);
        end
    endtask

    task automatic testStart();
        logic sawLeft;
        logic sawRight;
        driveInputs(1'b1, ROAD_STRAIGHT);
        waitLamp(LAMP_START);
        waitLamp(LAMP_COUNT);
        waitLamp(LAMP_STRAIGHT);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_FWD, WHEEL_FWD}), 1'b0);
        driveInputs(1'b1, ROAD_RIGHT_SLIGHT);
        settleCycles(8);
        checkRoad("led[2:0]", roadCode_t'(led[2:0]), ROAD_RIGHT_SLIGHT);
        sawLeft  = 1'b0;
        sawRight = 1'b0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            sawLeft  = sawLeft | motor.pwmLeft;
            sawRight = sawRight | motor.pwmRight;
        end
        checkMotor("motor", motorCmd_t'({sawLeft, sawRight, motor.leftDir, motor.rightDir}),
                   motorCmd_t'({1'b0, 1'b1, WHEEL_OFF, WHEEL_FWD}), 1'b1);
    endtask

    task automatic testLostLine();
        driveInputs(1'b1, ROAD_LOST);
        waitLamp(LAMP_STOP);
        checkLedBar("led[9:4]", led[9:4], 6'b111111);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_OFF, WHEEL_OFF}), 1'b1);
        waitLamp(LAMP_BACK);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_REV, WHEEL_REV}), 1'b0);
        driveInputs(1'b1, ROAD_TURN111);
        waitLamp(LAMP_STOP);
        waitLamp(LAMP_LEFT);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_REV, WHEEL_FWD}), 1'b0);
    endtask

    task automatic testJunction();
        driveInputs(1'b1, ROAD_STRAIGHT);
        waitLamp(LAMP_COUNT);
        waitLamp(LAMP_STRAIGHT);
        driveInputs(1'b1, ROAD_TURN111);
        waitLamp(LAMP_CHOOSE);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_REV, WHEEL_FWD}), 1'b0);
        // leave the mark, then meet it again
        driveInputs(1'b1, ROAD_STRAIGHT);
        settleCycles(8);
        driveInputs(1'b1, ROAD_TURN111);
        settleCycles(8);
        checkLedLamp("led[15:11]", led[15:11], LAMP_STRAIGHT);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_FWD, WHEEL_FWD}), 1'b0);
    endtask

    task automatic testRunOff();
        driveInputs(1'b0, roadCode_t'(track));
        waitLamp(LAMP_IDLE);
        checkMotor("motor", motor, motorCmd_t'({1'b0, 1'b0, WHEEL_OFF, WHEEL_OFF}), 1'b1);
    endtask

    initial begin
        rst       = 1'b1;
        runEnable = 1'b0;
        track     = '0;
        lfsr      = 32'h9deb;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testRoadCodes();
        testStart();
        testLostLine();
        testRunOff();
        testJunction();
        testRunOff();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* trackSampler.sv */
module trackSampler import lineFollowerPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  trackRaw_t track,
    output roadCode_t road
);

    trackRaw_t syncA;
    trackRaw_t syncB;
    // older samples with index 0 the newest
    trackRaw_t history [FILTER_DEPTH-1];
    logic      agree;

    always_comb begin
        agree = 1'b1;
        for (int i = 0; i < FILTER_DEPTH - 1; i++) begin
            if (history[i] != syncB) begin
                agree = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncA <= '0;
            syncB <= '0;
            for (int i = 0; i < FILTER_DEPTH - 1; i++) begin
                history[i] <= '0;
            end
            road <= ROAD_LOST;
        end else begin
            syncA      <= track;
            syncB      <= syncA;
            history[0] <= syncB;
            for (int i = 1; i < FILTER_DEPTH - 1; i++) begin
                history[i] <= history[i-1];
            end
            // edge chatter never gets a full run of equal samples
            if (agree) begin
                road <= roadCode_t'(syncB);
            end
        end
    end

endmodule
